/* zic_pkg.sv */
package zic_pkg;

	// Widths of the MMR bus and the source index
	localparam int ZIC_ADDR_W = 16;
	localparam int ZIC_DATA_W = 32;
	localparam int ZIC_BYTE_W = 8;
	localparam int ZIC_IDX_W  = 6;

	typedef logic [ZIC_ADDR_W-1:0] zic_addr_t;
	typedef logic [ZIC_DATA_W-1:0] zic_data_t;
	typedef logic [ZIC_BYTE_W-1:0] zic_byte_t;
	typedef logic [ZIC_IDX_W-1:0]  zic_irq_idx_t;

	// Each source owns four byte addresses
	localparam int ZIC_OFS_W      = 2;
	localparam int ZIC_REG_STRIDE = 4;

	// Register offset inside a source slot
	typedef enum logic [ZIC_OFS_W-1:0]
	{
		ZIC_SEL_IP   = 2'd0,
		ZIC_SEL_IE   = 2'd1,
		ZIC_SEL_ATTR = 2'd2,
		ZIC_SEL_CTL  = 2'd3
	} zic_reg_sel_e;

	localparam zic_byte_t ZIC_ATTR_VAL = 8'hC0;

	// CTL reset values fall by a fixed step from source 0 upwards
	localparam zic_byte_t ZIC_CTL_RST_TOP  = 8'hFF;
	localparam int        ZIC_CTL_RST_STEP = 4;

	function automatic zic_byte_t zic_ctl_reset_value(input zic_irq_idx_t idx);
		zic_byte_t dec;
		dec = zic_byte_t'(ZIC_CTL_RST_STEP * int'(idx));
		return ZIC_CTL_RST_TOP - dec;
	endfunction

endpackage

/* zic_wr_if.sv */
`timescale 1ns/100ps

// Decoded register write, one strobe per writable register
interface zic_wr_if;

	logic                   wr_ip;
	logic                   wr_ie;
	logic                   wr_ctl;
	zic_pkg::zic_irq_idx_t  wr_idx;
	zic_pkg::zic_data_t     wr_data;

	modport decoder
	(
		output wr_ip,
		output wr_ie,
		output wr_ctl,
		output wr_idx,
		output wr_data
	);

	modport bank
	(
		input wr_ip,
		input wr_ie,
		input wr_ctl,
		input wr_idx,
		input wr_data
	);

endinterface

/* zic_mmr_decode.sv */
`timescale 1ns/100ps

module zic_mmr_decode #(
	parameter int                 NUM_IRQ  = 48,
	parameter zic_pkg::zic_addr_t MMR_BASE = 16'h1000
)
(
	input  zic_pkg::zic_addr_t      wr_addr_i,
	input  zic_pkg::zic_data_t      wr_data_i,
	input  logic                    wr_en_i,
	input  zic_pkg::zic_addr_t      rd_addr_i,
	input  logic                    rd_en_i,
	zic_wr_if.decoder               wr,
	output logic                    rd_req_o,
	output logic                    rd_oob_o,
	output zic_pkg::zic_irq_idx_t   rd_idx_o,
	output zic_pkg::zic_reg_sel_e   rd_sel_o
);

	localparam int MAP_LO = int'(MMR_BASE);
	localparam int MAP_HI = int'(MMR_BASE) + zic_pkg::ZIC_REG_STRIDE * NUM_IRQ;

	function automatic logic in_map(input zic_pkg::zic_addr_t addr);
		return (int'(addr) >= MAP_LO) && (int'(addr) < MAP_HI);
	endfunction

	zic_pkg::zic_addr_t     wr_ofs;
	zic_pkg::zic_addr_t     rd_ofs;
	zic_pkg::zic_reg_sel_e  wr_sel;
	logic                   wr_hit;
	logic                   rd_hit;

	// Offset from the base, split into source index and register select
	assign wr_ofs = wr_addr_i - MMR_BASE;
	assign rd_ofs = rd_addr_i - MMR_BASE;
	assign wr_hit = in_map(wr_addr_i);
	assign rd_hit = in_map(rd_addr_i);
	assign wr_sel = zic_pkg::zic_reg_sel_e'(wr_ofs[zic_pkg::ZIC_OFS_W-1:0]);

	assign wr.wr_idx  = wr_ofs[zic_pkg::ZIC_OFS_W +: zic_pkg::ZIC_IDX_W];
	assign wr.wr_data = wr_data_i;

	always_comb
	begin
		wr.wr_ip  = 1'b0;
		wr.wr_ie  = 1'b0;
		wr.wr_ctl = 1'b0;
		if (wr_en_i && wr_hit)
		begin
			case (wr_sel)
				zic_pkg::ZIC_SEL_IP:  wr.wr_ip  = 1'b1;
				zic_pkg::ZIC_SEL_IE:  wr.wr_ie  = 1'b1;
				zic_pkg::ZIC_SEL_CTL: wr.wr_ctl = 1'b1;
				// ATTR is read only
				default: ;
			endcase
		end
	end

	assign rd_req_o = rd_en_i && rd_hit;
	assign rd_oob_o = rd_en_i && !rd_hit;
	assign rd_idx_o = rd_ofs[zic_pkg::ZIC_OFS_W +: zic_pkg::ZIC_IDX_W];
	assign rd_sel_o = zic_pkg::zic_reg_sel_e'(rd_ofs[zic_pkg::ZIC_OFS_W-1:0]);

	// Range check needs a known address on every enabled access
	always_comb
	begin
		a_wr_addr_known: assert #0 (!wr_en_i || !$isunknown(wr_addr_i))
			else $error("write enabled with unknown address");
		a_rd_addr_known: assert #0 (!rd_en_i || !$isunknown(rd_addr_i))
			else $error("read enabled with unknown address");
	end

endmodule

/* zic_pend_en_bank.sv */
`timescale 1ns/100ps

module zic_pend_en_bank #(
	parameter int NUM_IRQ = 48
)
(
	input  logic                zic_clk,
	input  logic                zic_rst,
	input  logic                wdt_reset_i,
	zic_wr_if.bank              wr,
	input  logic [NUM_IRQ-1:0]  zic_int_pending_i,
	input  logic                zic_int_pending_valid_i,
	input  logic [NUM_IRQ-1:0]  zic_int_enable_i,
	input  logic                zic_int_enable_valid_i,
	output logic [NUM_IRQ-1:0]  ip_o,
	output logic [NUM_IRQ-1:0]  ie_o,
	output logic [NUM_IRQ-1:0]  zic_int_en_o
);

	logic [NUM_IRQ-1:0] ip_q;
	logic [NUM_IRQ-1:0] ie_q;
	logic [NUM_IRQ-1:0] ip_nxt;
	logic [NUM_IRQ-1:0] ie_nxt;

	// Hardware load replaces the whole vector, a software write then overrides one bit
	function automatic logic [NUM_IRQ-1:0] next_vec(
		input logic [NUM_IRQ-1:0]    cur,
		input logic                  hw_valid,
		input logic [NUM_IRQ-1:0]    hw_vec,
		input logic                  sw_wr,
		input zic_pkg::zic_irq_idx_t sw_idx,
		input logic                  sw_bit
	);
		logic [NUM_IRQ-1:0] nxt;
		nxt = hw_valid ? hw_vec : cur;
		if (sw_wr)
		begin
			nxt[sw_idx] = sw_bit;
		end
		return nxt;
	endfunction

	assign ip_nxt = next_vec(ip_q, zic_int_pending_valid_i, zic_int_pending_i,
		wr.wr_ip, wr.wr_idx, wr.wr_data[0]);
	assign ie_nxt = next_vec(ie_q, zic_int_enable_valid_i, zic_int_enable_i,
		wr.wr_ie, wr.wr_idx, wr.wr_data[0]);

	always_ff @(posedge zic_clk or negedge zic_rst)
	begin
		if (!zic_rst)
		begin
			ip_q <= '0;
			ie_q <= '0;
		end
		else if (wdt_reset_i)
		begin
			ip_q <= '0;
			ie_q <= '0;
		end
		else
		begin
			ip_q <= ip_nxt;
			ie_q <= ie_nxt;
		end
	end

	assign ip_o = ip_q;
	assign ie_o = ie_q;

	// Enable vector leaves straight from the IE flops
	assign zic_int_en_o = ie_q;

	a_pend_known: assert property (@(posedge zic_clk) disable iff (!zic_rst)
		zic_int_pending_valid_i |-> !$isunknown(zic_int_pending_i))
		else $error("pending load vector has X bits");

	a_en_known: assert property (@(posedge zic_clk) disable iff (!zic_rst)
		zic_int_enable_valid_i |-> !$isunknown(zic_int_enable_i))
		else $error("enable load vector has X bits");

endmodule

/* zic_level_bank.sv */
`timescale 1ns/100ps

module zic_level_bank #(
	parameter int NUM_IRQ = 48
)
(
	input  logic                zic_clk,
	input  logic                zic_rst,
	input  logic                wdt_reset_i,
	zic_wr_if.bank              wr,
	output zic_pkg::zic_byte_t  ctl_o [NUM_IRQ]
);

	zic_pkg::zic_byte_t ctl_q [NUM_IRQ];

	for (genvar g = 0; g < NUM_IRQ; g++)
	begin : g_ctl
		localparam zic_pkg::zic_byte_t RST_VAL =
			zic_pkg::zic_ctl_reset_value(zic_pkg::zic_irq_idx_t'(g));

		logic hit;

		assign hit = wr.wr_ctl && (wr.wr_idx == zic_pkg::zic_irq_idx_t'(g));

		// Power-on value follows the per-source rule, watchdog forces zero
		always_ff @(posedge zic_clk or negedge zic_rst)
		begin
			if (!zic_rst)
			begin
				ctl_q[g] <= RST_VAL;
			end
			else if (wdt_reset_i)
			begin
				ctl_q[g] <= '0;
			end
			else if (hit)
			begin
				ctl_q[g] <= wr.wr_data[zic_pkg::ZIC_BYTE_W-1:0];
			end
		end
	end

	assign ctl_o = ctl_q;

endmodule

/* zic_mmr_readback.sv */
`timescale 1ns/100ps

module zic_mmr_readback #(
	parameter int NUM_IRQ = 48
)
(
	input  logic                   zic_clk,
	input  logic                   zic_rst,
	input  logic                   rd_req_i,
	input  logic                   rd_oob_i,
	input  zic_pkg::zic_irq_idx_t  rd_idx_i,
	input  zic_pkg::zic_reg_sel_e  rd_sel_i,
	input  logic [NUM_IRQ-1:0]     ip_i,
	input  logic [NUM_IRQ-1:0]     ie_i,
	input  zic_pkg::zic_byte_t     ctl_i [NUM_IRQ],
	output zic_pkg::zic_data_t     zic_mmr_read_data_o,
	output logic                   zic_mmr_read_valid_o
);

	zic_pkg::zic_data_t src_word;
	zic_pkg::zic_data_t rd_word;
	logic               valid_q;

	// CTL | ATTR | IE | IP, one byte each
	assign src_word = {ctl_i[rd_idx_i], zic_pkg::ZIC_ATTR_VAL,
		7'd0, ie_i[rd_idx_i], 7'd0, ip_i[rd_idx_i]};

	// Every offset of a source returns the whole packed word
	assign rd_word = rd_req_i ? src_word : '0;

	always_ff @(posedge zic_clk or negedge zic_rst)
	begin
		if (!zic_rst)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= rd_req_i || rd_oob_i;
		end
	end

	always_ff @(posedge zic_clk)
	begin
		if (rd_req_i || rd_oob_i)
		begin
			zic_mmr_read_data_o <= rd_word;
		end
	end

	assign zic_mmr_read_valid_o = valid_q;

	a_rd_latency: assert property (@(posedge zic_clk) disable iff (!zic_rst)
		(rd_req_i || rd_oob_i) |=>
			(zic_mmr_read_valid_o && !$isunknown(zic_mmr_read_data_o)))
		else $error("no valid known read word one cycle after request");

endmodule

/* zic_mmr_ctrl.sv */
`timescale 1ns/100ps

module zic_mmr_ctrl #(
	parameter int                 NUM_IRQ  = 48,
	parameter zic_pkg::zic_addr_t MMR_BASE = 16'h1000
)
(
	input  logic                zic_clk,
	input  logic                zic_rst,
	input  logic                wdt_reset_i,
	input  zic_pkg::zic_addr_t  zic_mmr_write_addr_i,
	input  zic_pkg::zic_data_t  zic_mmr_write_data_i,
	input  logic                zic_mmr_write_en_i,
	input  zic_pkg::zic_addr_t  zic_mmr_read_addr_i,
	input  logic                zic_mmr_read_en_i,
	input  logic [NUM_IRQ-1:0]  zic_int_pending_i,
	input  logic                zic_int_pending_valid_i,
	input  logic [NUM_IRQ-1:0]  zic_int_enable_i,
	input  logic                zic_int_enable_valid_i,
	output logic [NUM_IRQ-1:0]  zic_int_en_o,
	output zic_pkg::zic_data_t  zic_mmr_read_data_o,
	output logic                zic_mmr_read_valid_o
);

	logic                   rd_req;
	logic                   rd_oob;
	zic_pkg::zic_irq_idx_t  rd_idx;
	zic_pkg::zic_reg_sel_e  rd_sel;
	logic [NUM_IRQ-1:0]     ip;
	logic [NUM_IRQ-1:0]     ie;
	zic_pkg::zic_byte_t     ctl [NUM_IRQ];

	zic_wr_if wr_bus ();

	zic_mmr_decode #(
		.NUM_IRQ  (NUM_IRQ),
		.MMR_BASE (MMR_BASE)
	) u_decode (
		.wr_addr_i (zic_mmr_write_addr_i),
		.wr_data_i (zic_mmr_write_data_i),
		.wr_en_i   (zic_mmr_write_en_i),
		.rd_addr_i (zic_mmr_read_addr_i),
		.rd_en_i   (zic_mmr_read_en_i),
		.wr        (wr_bus),
		.rd_req_o  (rd_req),
		.rd_oob_o  (rd_oob),
		.rd_idx_o  (rd_idx),
		.rd_sel_o  (rd_sel)
	);

	zic_pend_en_bank #(
		.NUM_IRQ (NUM_IRQ)
	) u_pend_en (
		.zic_clk                 (zic_clk),
		.zic_rst                 (zic_rst),
		.wdt_reset_i             (wdt_reset_i),
		.wr                      (wr_bus),
		.zic_int_pending_i       (zic_int_pending_i),
		.zic_int_pending_valid_i (zic_int_pending_valid_i),
		.zic_int_enable_i        (zic_int_enable_i),
		.zic_int_enable_valid_i  (zic_int_enable_valid_i),
		.ip_o                    (ip),
		.ie_o                    (ie),
		.zic_int_en_o            (zic_int_en_o)
	);

	zic_level_bank #(
		.NUM_IRQ (NUM_IRQ)
	) u_level (
		.zic_clk     (zic_clk),
		.zic_rst     (zic_rst),
		.wdt_reset_i (wdt_reset_i),
		.wr          (wr_bus),
		.ctl_o       (ctl)
	);

	zic_mmr_readback #(
		.NUM_IRQ (NUM_IRQ)
	) u_readback (
		.zic_clk              (zic_clk),
		.zic_rst              (zic_rst),
		.rd_req_i             (rd_req),
		.rd_oob_i             (rd_oob),
		.rd_idx_i             (rd_idx),
		.rd_sel_i             (rd_sel),
		.ip_i                 (ip),
		.ie_i                 (ie),
		.ctl_i                (ctl),
		.zic_mmr_read_data_o  (zic_mmr_read_data_o),
		.zic_mmr_read_valid_o (zic_mmr_read_valid_o)
	);

endmodule

/* tb_zic_mmr_ctrl.sv */
`timescale 1ns/100ps

module tb_zic_mmr_ctrl;

	localparam int                 NUM_IRQ    = 48;
	localparam zic_pkg::zic_addr_t MMR_BASE   = 16'h1000;
	localparam int                 RST_CYCLES = 8;
	localparam int                 NUM_RAND   = 200;
	localparam logic [7:0]         ATTR_BYTE  = 8'hC0;
	// About four times the cycles that the five phases take
	localparam int MAX_CYCLES = 4 * (RST_CYCLES + 2 * NUM_RAND + 8 * NUM_IRQ + 64);

	logic                zic_clk;
	logic                zic_rst;
	logic                wdt;
	zic_pkg::zic_addr_t  wr_addr;
	zic_pkg::zic_data_t  wr_data;
	logic                wr_en;
	zic_pkg::zic_addr_t  rd_addr;
	logic                rd_en;
	logic [NUM_IRQ-1:0]  pend_vec;
	logic                pend_valid;
	logic [NUM_IRQ-1:0]  en_vec;
	logic                en_valid;
	logic [NUM_IRQ-1:0]  int_en;
	zic_pkg::zic_data_t  rd_data;
	logic                rd_valid;

	// Reference model of the register state
	logic [NUM_IRQ-1:0]  m_ip;
	logic [NUM_IRQ-1:0]  m_ie;
	logic [7:0]          m_ctl [NUM_IRQ];
	logic                exp_valid;
	zic_pkg::zic_data_t  exp_word;

	int                  rd_issued = 0;
	int                  rd_seen = 0;
	int                  cycle_count = 0;
	logic [31:0]         rng_state = 32'd92;

	zic_mmr_ctrl #(
		.NUM_IRQ  (NUM_IRQ),
		.MMR_BASE (MMR_BASE)
	) DUT (
		.zic_clk                 (zic_clk),
		.zic_rst                 (zic_rst),
		.wdt_reset_i             (wdt),
		.zic_mmr_write_addr_i    (wr_addr),
		.zic_mmr_write_data_i    (wr_data),
		.zic_mmr_write_en_i      (wr_en),
		.zic_mmr_read_addr_i     (rd_addr),
		.zic_mmr_read_en_i       (rd_en),
		.zic_int_pending_i       (pend_vec),
		.zic_int_pending_valid_i (pend_valid),
		.zic_int_enable_i        (en_vec),
		.zic_int_enable_valid_i  (en_valid),
		.zic_int_en_o            (int_en),
		.zic_mmr_read_data_o     (rd_data),
		.zic_mmr_read_valid_o    (rd_valid)
	);

	initial
	begin
		zic_clk = 1'b0;
		forever #4 zic_clk = ~zic_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int rand_idx();
		return int'(rand32() % NUM_IRQ);
	endfunction

	function automatic logic [NUM_IRQ-1:0] rand_vec();
		logic [63:0] both;
		both = {rand32(), rand32()};
		return both[NUM_IRQ-1:0];
	endfunction

	function automatic logic addr_valid(input zic_pkg::zic_addr_t addr);
		return (int'(addr) >= int'(MMR_BASE)) && (int'(addr) < int'(MMR_BASE) + 4 * NUM_IRQ);
	endfunction

	function automatic int src_of(input zic_pkg::zic_addr_t addr);
		return (int'(addr) - int'(MMR_BASE)) / 4;
	endfunction

	function automatic int reg_of(input zic_pkg::zic_addr_t addr);
		return (int'(addr) - int'(MMR_BASE)) % 4;
	endfunction

	function automatic zic_pkg::zic_addr_t reg_addr(input int src, input int ofs);
		return MMR_BASE + zic_pkg::zic_addr_t'(4 * src + ofs);
	endfunction

	function automatic logic [7:0] ctl_power_on(input int src);
		return 8'(255 - 4 * src);
	endfunction

	function automatic zic_pkg::zic_data_t expected_word(input zic_pkg::zic_addr_t addr);
		int s;
		if (!addr_valid(addr))
		begin
			return '0;
		end
		s = src_of(addr);
		return {m_ctl[s], ATTR_BYTE, 7'd0, m_ie[s], 7'd0, m_ip[s]};
	endfunction

	always @(posedge zic_clk or negedge zic_rst)
	begin : model_update
		logic [NUM_IRQ-1:0] ip_n;
		logic [NUM_IRQ-1:0] ie_n;
		logic               hit;
		int                 src;
		int                 ofs;
		if (!zic_rst)
		begin
			m_ip <= '0;
			m_ie <= '0;
			for (int i = 0; i < NUM_IRQ; i++)
			begin
				m_ctl[i] <= ctl_power_on(i);
			end
			exp_valid <= 1'b0;
			exp_word  <= '0;
		end
		else
		begin
			// Read sees the state from before this edge
			exp_valid <= rd_en;
			if (rd_en)
			begin
				exp_word <= expected_word(rd_addr);
			end
			hit  = wr_en && addr_valid(wr_addr);
			src  = src_of(wr_addr);
			ofs  = reg_of(wr_addr);
			ip_n = pend_valid ? pend_vec : m_ip;
			ie_n = en_valid ? en_vec : m_ie;
			if (hit && ofs == 0)
			begin
				ip_n[src] = wr_data[0];
			end
			if (hit && ofs == 1)
			begin
				ie_n[src] = wr_data[0];
			end
			if (wdt)
			begin
				m_ip <= '0;
				m_ie <= '0;
				for (int i = 0; i < NUM_IRQ; i++)
				begin
					m_ctl[i] <= 8'h00;
				end
			end
			else
			begin
				m_ip <= ip_n;
				m_ie <= ie_n;
				if (hit && ofs == 3)
				begin
					m_ctl[src] <= wr_data[7:0];
				end
			end
		end
	end

	task automatic report_fail(input string msg);
		$display("FAIL t=%0t: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "check failed");
	endtask

	a_rd_valid: assert property (@(posedge zic_clk) disable iff (!zic_rst)
		rd_valid == exp_valid)
		else report_fail($sformatf("read valid %b, expected %b",
			$sampled(rd_valid), $sampled(exp_valid)));

	a_rd_data: assert property (@(posedge zic_clk) disable iff (!zic_rst)
		exp_valid |-> rd_data == exp_word)
		else report_fail($sformatf("read data %h, expected %h",
			$sampled(rd_data), $sampled(exp_word)));

	a_int_en: assert property (@(posedge zic_clk) disable iff (!zic_rst)
		int_en == m_ie)
		else report_fail($sformatf("enable vector %h, expected %h",
			$sampled(int_en), $sampled(m_ie)));

	always @(negedge zic_clk)
	begin
		if (zic_rst && rd_valid)
		begin
			rd_seen++;
		end
	end

	always @(posedge zic_clk)
	begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	// One clock cycle of inputs, applied on the falling edge
	task automatic drive(input logic we, input zic_pkg::zic_addr_t wa, input zic_pkg::zic_data_t wd,
		input logic re, input zic_pkg::zic_addr_t ra, input logic pv, input logic [NUM_IRQ-1:0] pvec,
		input logic ev, input logic [NUM_IRQ-1:0] evec, input logic w_clr);
		@(negedge zic_clk);
		wr_en      = we;
		wr_addr    = wa;
		wr_data    = wd;
		rd_en      = re;
		rd_addr    = ra;
		pend_valid = pv;
		pend_vec   = pvec;
		en_valid   = ev;
		en_vec     = evec;
		wdt        = w_clr;
		if (re)
		begin
			rd_issued++;
		end
	endtask

	task automatic write_reg(input zic_pkg::zic_addr_t a, input zic_pkg::zic_data_t d);
		drive(1'b1, a, d, 1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0);
	endtask

	task automatic read_reg(input zic_pkg::zic_addr_t a);
		drive(1'b0, '0, '0, 1'b1, a, 1'b0, '0, 1'b0, '0, 1'b0);
	endtask

	task automatic idle(input int n);
		repeat (n) drive(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0);
	endtask

	task automatic read_all(input int ofs);
		for (int i = 0; i < NUM_IRQ; i++)
		begin
			read_reg(reg_addr(i, ofs));
		end
	endtask

	task automatic rand_write_read();
		int k;
		int pick;
		zic_pkg::zic_addr_t a;
		k    = rand_idx();
		pick = int'(rand32() % 3);
		a    = reg_addr(k, (pick == 2) ? 3 : pick);
		write_reg(a, rand32());
		read_reg(a);
	endtask

	initial
	begin : stimulus
		logic [NUM_IRQ-1:0] vec;
		int                 k;
		zic_pkg::zic_addr_t a;
		zic_pkg::zic_addr_t oob [7];
		wr_en      = 1'b0;
		wr_addr    = '0;
		wr_data    = '0;
		rd_en      = 1'b0;
		rd_addr    = '0;
		pend_valid = 1'b0;
		pend_vec   = '0;
		en_valid   = 1'b0;
		en_vec     = '0;
		wdt        = 1'b0;
		zic_rst    = 1'b0;
		// The last one aliases source 0 CTL in its low offset bits
		oob = '{MMR_BASE - 16'd1, MMR_BASE - 16'd4, reg_addr(NUM_IRQ, 0),
			reg_addr(NUM_IRQ, 3), 16'h0000, 16'hFFFF, reg_addr(64, 3)};
		repeat (RST_CYCLES) @(posedge zic_clk);
		@(negedge zic_clk);
		zic_rst = 1'b1;

		// Power-on CTL values of every source
		read_all(3);
		idle(2);

		repeat (NUM_RAND) rand_write_read();
		// Read and write of one register at the same edge
		repeat (16)
		begin
			k = rand_idx();
			a = reg_addr(k, 3);
			drive(1'b1, a, rand32(), 1'b1, a, 1'b0, '0, 1'b0, '0, 1'b0);
			read_reg(a);
		end
		read_all(0);
		read_all(1);
		idle(2);

		// Hardware loads, then loads racing a software write
		drive(1'b0, '0, '0, 1'b0, '0, 1'b1, rand_vec(), 1'b0, '0, 1'b0);
		read_all(0);
		vec = rand_vec();
		k   = rand_idx();
		drive(1'b1, reg_addr(k, 0), {31'd0, ~vec[k]}, 1'b0, '0, 1'b1, vec, 1'b0, '0, 1'b0);
		vec = rand_vec();
		k   = rand_idx();
		drive(1'b1, reg_addr(k, 1), {31'd0, ~vec[k]}, 1'b0, '0, 1'b0, '0, 1'b1, vec, 1'b0);
		read_all(0);
		idle(2);

		// ATTR and out-of-range writes leave the state alone
		for (int i = 0; i < 8; i++)
		begin
			write_reg(reg_addr(i * 6, 2), rand32());
		end
		foreach (oob[i])
		begin
			write_reg(oob[i], rand32());
			read_reg(oob[i]);
		end
		read_all(2);
		idle(2);

		// Watchdog clears to zero, writes work again afterwards
		drive(1'b0, '0, '0, 1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b1);
		read_all(3);
		repeat (24) rand_write_read();
		idle(4);

		if (rd_seen == rd_issued)
		begin
			$display("Simulation PASSED");
			$finish;
		end
		else
		begin
			report_fail($sformatf("%0d reads returned, expected %0d", rd_seen, rd_issued));
		end
	end

endmodule

/* sources.f */
zic_pkg.sv
zic_wr_if.sv
zic_mmr_decode.sv
zic_pend_en_bank.sv
zic_level_bank.sv
zic_mmr_readback.sv
zic_mmr_ctrl.sv
tb_zic_mmr_ctrl.sv
